// File: nibble_regs_vectors.txt
// src_dst_inc_immed_alu_zero_carry_rddata_expwe_expaddr_expwdata, all hex
// src, dst and immed two digits, expaddr three, the others one digit
00_12_0_00_0_0_0_0_1_000_0
11_12_0_00_0_0_0_0_1_000_1
0F_00_0_3C_0_0_0_0_0_000_0
10_01_0_3C_0_0_0_0_0_000_0
00_02_0_00_0_0_0_0_0_000_0
01_03_0_00_0_0_0_0_0_000_0
02_12_0_00_0_0_0_0_1_000_C
03_12_0_00_0_0_0_0_1_000_3
0F_05_0_45_0_0_0_0_0_000_0
10_06_0_45_0_0_0_0_0_000_0
0F_07_0_03_0_0_0_0_0_000_0
0F_08_0_ED_0_0_0_0_0_000_0
10_09_0_ED_0_0_0_0_0_000_0
10_0A_0_F0_0_0_0_0_0_000_0
0F_0B_0_F7_0_0_0_0_0_000_0
10_0C_0_F7_0_0_0_0_0_000_0
12_00_1_00_0_0_0_9_0_345_0
00_13_0_00_0_0_0_0_1_FED_9
14_01_0_07_0_0_0_6_0_007_0
01_15_3_00_0_0_0_0_1_0F7_6
0F_08_0_FF_0_0_0_0_0_000_0
10_09_0_FF_0_0_0_0_0_000_0
0F_0A_0_02_0_0_0_0_0_000_0
02_13_2_00_0_0_0_0_1_2FF_C
0F_04_0_0F_0_0_0_0_0_000_0
04_02_0_00_0_0_0_0_0_000_0
0D_04_0_00_5_0_0_0_0_000_0
04_12_0_00_0_0_0_0_1_346_5
0E_13_0_00_8_1_0_0_1_200_8
0D_15_0_00_3_0_1_0_1_0F8_3
04_12_0_00_0_0_0_0_1_346_6
02_12_0_00_0_0_0_0_1_346_F

// File: nibble_regs.f
nibble_regs_pkg.sv
reg_bus_if.sv
micro_sequencer.sv
index_regs.sv
data_regs.sv
nibble_regs.sv
nibble_regs_asserts.sv
nibble_regs_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= nibble_regs_tb
FILELIST  ?= nibble_regs.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: nibble_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_regs_tb;
  import nibble_regs_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 10;
  localparam int MAX_LINES       = 64;
  localparam int CYCLES_PER_LINE = 40;
  localparam int BUSY_LIMIT      = 8;
  localparam int VEC_WIDTH       = 64;

  logic    clk;
  logic    rst_n;
  logic    start;
  sel_t    src_sel;
  sel_t    dst_sel;
  inc_t    inc_sel;
  nibble_t alu;
  logic    alu_zero;
  logic    alu_carry;
  imm_t    immed;
  nibble_t mem_read_data = '0;
  logic    busy;
  logic    mem_write_en;
  addr_t   mem_addr;
  nibble_t mem_write_data;

  logic [VEC_WIDTH-1:0] vectors [MAX_LINES];
  nibble_t line_rd;
  addr_t   last_addr = '0;
  int      num_lines;
  int      errors;

  nibble_regs nibble_regs_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .src_sel        (src_sel),
    .dst_sel        (dst_sel),
    .inc_sel        (inc_sel),
    .alu            (alu),
    .alu_zero       (alu_zero),
    .alu_carry      (alu_carry),
    .immed          (immed),
    .mem_read_data  (mem_read_data),
    .busy           (busy),
    .mem_write_en   (mem_write_en),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------------
  // Read data shows up once the address has been stable for a cycle
  always @(negedge clk) begin
    if (mem_addr == last_addr) begin
      mem_read_data <= line_rd;
    end else begin
      mem_read_data <= '0;
    end
    last_addr <= mem_addr;
  end

  initial begin
    wait (num_lines > 0);
    #((RESET_CYCLES + CYCLES_PER_LINE * num_lines) * CLK_PERIOD);
    $display("Watchdog expired before all %0d vector lines finished", num_lines);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  // ------------------------------------------------------------------
  // One microinstruction per vector line
  // ------------------------------------------------------------------
  task automatic run_line(input int index);
    logic [VEC_WIDTH-1:0] vec;
    int idle;
    int cycles;
    int busy_cycles;
    int writes;

    vec         = vectors[index];
    idle        = $urandom % 4;
    cycles      = 0;
    busy_cycles = 0;
    writes      = 0;
    repeat (idle) @(negedge clk);

    @(negedge clk);
    src_sel   = vec[60:56];
    dst_sel   = vec[52:48];
    inc_sel   = vec[45:44];
    immed     = vec[43:36];
    alu       = vec[35:32];
    alu_zero  = vec[28];
    alu_carry = vec[24];
    line_rd   = vec[23:20];
    start     = 1'b1;

    do begin
      @(negedge clk);
      cycles++;
      // Start stays high over the FETCH and WRITE edges
      if (!busy) begin
        start = 1'b0;
      end
      if (busy) begin
        busy_cycles++;
        check_value($sformatf("line %0d mem_addr", index),
                    32'(mem_addr), 32'(vec[15:4]));
        if (mem_write_en) begin
          writes++;
          check_value($sformatf("line %0d mem_write_data", index),
                      32'(mem_write_data), 32'(vec[3:0]));
        end
      end
    end while ((busy || cycles < 2) && cycles < BUSY_LIMIT);
    start = 1'b0;

    if (busy) begin
      errors++;
      $display("Busy still high %0d cycles after start on line %0d", cycles, index);
    end
    check_value($sformatf("line %0d busy cycles", index), busy_cycles, 32'd2);
    check_value($sformatf("line %0d memory writes", index), writes, 32'(vec[19:16]));
  endtask

  initial begin
    int count;

    void'($urandom(32'h7e8));
    rst_n     = 1'b0;
    start     = 1'b0;
    src_sel   = SEL_A;
    dst_sel   = SEL_A;
    inc_sel   = INC_NONE;
    alu       = '0;
    alu_zero  = 1'b0;
    alu_carry = 1'b0;
    immed     = '0;
    line_rd   = '0;
    errors    = 0;
    num_lines = 0;

    for (int i = 0; i < MAX_LINES; i++) begin
      vectors[i] = '1;
    end
    $readmemh("nibble_regs_vectors.txt", vectors);
    count = 0;
    while (count < MAX_LINES && vectors[count][63:56] != 8'hFF) begin
      count++;
    end
    if (count == 0) begin
      errors++;
      $display("No vector lines could be read from nibble_regs_vectors.txt");
    end
    num_lines = count;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("busy after reset", 32'(busy), 32'd0);
    check_value("mem_write_en after reset", 32'(mem_write_en), 32'd0);

    for (int i = 0; i < num_lines; i++) begin
      run_line(i);
    end

    @(negedge clk);
    $display("Checks done: %0d errors over %0d vector lines", errors, num_lines);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: nibble_regs_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_regs_asserts (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic busy,
  input wire logic mem_write_en
);

  // Idle from the edge after rst_n low
  reset_idle: assert property (
    @(posedge clk) !rst_n |=> !busy && !mem_write_en
  ) else $error("busy or mem_write_en high after reset");

  // Write strobe only in the WRITE cycle
  write_in_second_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_write_en |-> busy && $past(busy) && !$past(busy, 2)
  ) else $error("mem_write_en outside the second busy cycle");

  busy_two_cycles: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> $past(busy, 2) && !$past(busy, 3)
  ) else $error("busy did not last exactly two cycles");

endmodule

bind nibble_regs nibble_regs_asserts nibble_regs_asserts_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .busy         (busy),
  .mem_write_en (mem_write_en)
);

`default_nettype wire

// File: nibble_regs.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_regs (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     start,
  input  wire nibble_regs_pkg::sel_t    src_sel,
  input  wire nibble_regs_pkg::sel_t    dst_sel,
  input  wire nibble_regs_pkg::inc_t    inc_sel,
  input  wire nibble_regs_pkg::nibble_t alu,
  input  wire logic                     alu_zero,
  input  wire logic                     alu_carry,
  input  wire nibble_regs_pkg::imm_t    immed,
  input  wire nibble_regs_pkg::nibble_t mem_read_data,
  output      logic                     busy,
  output      logic                     mem_write_en,
  output      nibble_regs_pkg::addr_t   mem_addr,
  output      nibble_regs_pkg::nibble_t mem_write_data
);

  reg_bus_if rbus ();

  micro_sequencer micro_sequencer_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .src_in (src_sel),
    .dst_in (dst_sel),
    .inc_in (inc_sel),
    .busy   (busy),
    .bus    (rbus.seq)
  );

  index_regs index_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus      (rbus.index),
    .immed    (immed),
    .mem_addr (mem_addr)
  );

  data_regs data_regs_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (rbus.data),
    .alu            (alu),
    .alu_zero       (alu_zero),
    .alu_carry      (alu_carry),
    .immed          (immed),
    .mem_read_data  (mem_read_data),
    .mem_write_en   (mem_write_en),
    .mem_write_data (mem_write_data)
  );

endmodule

`default_nettype wire

// File: data_regs.sv
`timescale 1ns/1ps
`default_nettype none

module data_regs (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  reg_bus_if.data                      bus,
  input  wire nibble_regs_pkg::nibble_t alu,
  input  wire logic                    alu_zero,
  input  wire logic                    alu_carry,
  input  wire nibble_regs_pkg::imm_t   immed,
  input  wire nibble_regs_pkg::nibble_t mem_read_data,
  output      logic                    mem_write_en,
  output      nibble_regs_pkg::nibble_t mem_write_data
);
  import nibble_regs_pkg::*;

  // Decimal is flag bit 2 and interrupt bit 3
  localparam int FLAG_CARRY = 0;
  localparam int FLAG_ZERO  = 1;

  nibble_t a;
  nibble_t b;
  nibble_t temp_a;
  nibble_t temp_b;
  nibble_t flags;
  nibble_t bus_value;

  // ------------------------------------------------------------------
  // Bus source mux
  // ------------------------------------------------------------------
  always_comb begin
    case (bus.src)
      SEL_A:              bus_value = a;
      SEL_B:              bus_value = b;
      SEL_TEMPA:          bus_value = temp_a;
      SEL_TEMPB:          bus_value = temp_b;
      SEL_FLAGS:          bus_value = flags;
      SEL_ALU,
      SEL_ALU_WITH_FLAGS: bus_value = alu;
      SEL_IMML:           bus_value = immed[3:0];
      SEL_IMMH:           bus_value = immed[7:4];
      SEL_ONE:            bus_value = 4'h1;
      SEL_XL, SEL_XH, SEL_XP,
      SEL_YL, SEL_YH, SEL_YP,
      SEL_SPL, SEL_SPH:   bus_value = bus.index_nibble;
      // Read data arrives by the write phase
      SEL_MX, SEL_MY,
      SEL_MN, SEL_MSP:    bus_value = mem_read_data;
      default:            bus_value = '0;
    endcase
  end

  assign bus.bus = bus_value;

  // ------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a      <= '0;
      b      <= '0;
      temp_a <= '0;
      temp_b <= '0;
      flags  <= '0;
    end else if (bus.write_phase) begin
      case (bus.dst)
        SEL_A:     a      <= bus_value;
        SEL_B:     b      <= bus_value;
        SEL_TEMPA: temp_a <= bus_value;
        SEL_TEMPB: temp_b <= bus_value;
        SEL_FLAGS: flags  <= bus_value;
        default:   ;
      endcase

      // ALU carry and zero copied, decimal and interrupt kept
      if (bus.src == SEL_ALU_WITH_FLAGS && bus.dst != SEL_FLAGS) begin
        flags[FLAG_CARRY] <= alu_carry;
        flags[FLAG_ZERO]  <= alu_zero;
      end
    end
  end

  // Memory write path
  assign mem_write_en   = bus.write_phase && sel_is_mem(bus.dst);
  assign mem_write_data = bus_value;

endmodule

`default_nettype wire

// File: index_regs.sv
`timescale 1ns/1ps
`default_nettype none

module index_regs (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  reg_bus_if.index                    bus,
  input  wire nibble_regs_pkg::imm_t  immed,
  output      nibble_regs_pkg::addr_t mem_addr
);
  import nibble_regs_pkg::*;

  addr_t         x;
  addr_t         y;
  logic [7:0]    sp;
  logic          x_hit;
  logic          y_hit;
  logic          sp_hit;
  sel_t          operand;
  nibble_t       index_value;

  assign x_hit  = bus.dst inside {SEL_XL, SEL_XH, SEL_XP};
  assign y_hit  = bus.dst inside {SEL_YL, SEL_YH, SEL_YP};
  assign sp_hit = bus.dst inside {SEL_SPL, SEL_SPH};

  // ------------------------------------------------------------------
  // Nibble writes and post-increment
  // ------------------------------------------------------------------
  // A register write beats the increment of the same register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x  <= '0;
      y  <= '0;
      sp <= '0;
    end else if (bus.write_phase) begin
      if (x_hit) begin
        case (bus.dst)
          SEL_XL:  x[3:0]  <= bus.bus;
          SEL_XH:  x[7:4]  <= bus.bus;
          default: x[11:8] <= bus.bus;
        endcase
      end else if (bus.inc == INC_X) begin
        // Page nibble stays put
        x <= {x[11:8], x[7:0] + 8'd1};
      end

      if (y_hit) begin
        case (bus.dst)
          SEL_YL:  y[3:0]  <= bus.bus;
          SEL_YH:  y[7:4]  <= bus.bus;
          default: y[11:8] <= bus.bus;
        endcase
      end else if (bus.inc == INC_Y) begin
        y <= {y[11:8], y[7:0] + 8'd1};
      end

      if (sp_hit) begin
        if (bus.dst == SEL_SPL) begin
          sp[3:0] <= bus.bus;
        end else begin
          sp[7:4] <= bus.bus;
        end
      end else if (bus.inc == INC_SP) begin
        sp <= sp + 8'd1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Memory address and source nibble
  // ------------------------------------------------------------------
  // Source operand wins when both are memory
  assign operand = sel_is_mem(bus.src) ? bus.src : bus.dst;

  always_comb begin
    case (operand)
      SEL_MX:  mem_addr = x;
      SEL_MY:  mem_addr = y;
      SEL_MN:  mem_addr = {4'h0, immed};
      SEL_MSP: mem_addr = {4'h0, sp};
      default: mem_addr = '0;
    endcase
  end

  always_comb begin
    case (bus.src)
      SEL_XL:  index_value = x[3:0];
      SEL_XH:  index_value = x[7:4];
      SEL_XP:  index_value = x[11:8];
      SEL_YL:  index_value = y[3:0];
      SEL_YH:  index_value = y[7:4];
      SEL_YP:  index_value = y[11:8];
      SEL_SPL: index_value = sp[3:0];
      SEL_SPH: index_value = sp[7:4];
      default: index_value = '0;
    endcase
  end

  assign bus.index_nibble = index_value;

endmodule

`default_nettype wire

// File: micro_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  start,
  input  wire nibble_regs_pkg::sel_t src_in,
  input  wire nibble_regs_pkg::sel_t dst_in,
  input  wire nibble_regs_pkg::inc_t inc_in,
  output      logic                  busy,
  reg_bus_if.seq                     bus
);
  import nibble_regs_pkg::*;

  seq_state_t state;

  // Fetch, then write, then back to idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    state <= start ? FETCH : IDLE;
        FETCH:   state <= WRITE;
        WRITE:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Selectors only taken on an accepted start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.src <= SEL_A;
      bus.dst <= SEL_A;
      bus.inc <= INC_NONE;
    end else if (state == IDLE && start) begin
      bus.src <= src_in;
      bus.dst <= dst_in;
      bus.inc <= inc_in;
    end
  end

  assign busy            = (state != IDLE);
  assign bus.write_phase = (state == WRITE);

endmodule

`default_nettype wire

// File: reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
  import nibble_regs_pkg::*;

  // Selectors latched for the microinstruction in flight
  sel_t    src;
  sel_t    dst;
  inc_t    inc;
  logic    write_phase;

  // Nibble on the internal bus
  nibble_t bus;
  // X, Y or SP nibble picked by src
  nibble_t index_nibble;

  modport seq (
    output src, dst, inc, write_phase
  );

  modport data (
    input  src, dst, write_phase, index_nibble,
    output bus
  );

  modport index (
    input  src, dst, inc, write_phase, bus,
    output index_nibble
  );

endinterface

`default_nettype wire

// File: nibble_regs_pkg.sv
`default_nettype none

package nibble_regs_pkg;

  typedef logic [3:0]  nibble_t;
  typedef logic [11:0] addr_t;
  typedef logic [7:0]  imm_t;
  typedef logic [4:0]  sel_t;
  typedef logic [1:0]  inc_t;

  // Bus selector codes, shared by source and destination
  localparam sel_t SEL_A              = 5'd0;
  localparam sel_t SEL_B              = 5'd1;
  localparam sel_t SEL_TEMPA          = 5'd2;
  localparam sel_t SEL_TEMPB          = 5'd3;
  localparam sel_t SEL_FLAGS          = 5'd4;
  localparam sel_t SEL_XL             = 5'd5;
  localparam sel_t SEL_XH             = 5'd6;
  localparam sel_t SEL_XP             = 5'd7;
  localparam sel_t SEL_YL             = 5'd8;
  localparam sel_t SEL_YH             = 5'd9;
  localparam sel_t SEL_YP             = 5'd10;
  localparam sel_t SEL_SPL            = 5'd11;
  localparam sel_t SEL_SPH            = 5'd12;
  localparam sel_t SEL_ALU            = 5'd13;
  localparam sel_t SEL_ALU_WITH_FLAGS = 5'd14;
  localparam sel_t SEL_IMML           = 5'd15;
  localparam sel_t SEL_IMMH           = 5'd16;
  localparam sel_t SEL_ONE            = 5'd17;
  localparam sel_t SEL_MX             = 5'd18;
  localparam sel_t SEL_MY             = 5'd19;
  localparam sel_t SEL_MN             = 5'd20;
  localparam sel_t SEL_MSP            = 5'd21;

  // Post-increment select
  localparam inc_t INC_NONE = 2'd0;
  localparam inc_t INC_X    = 2'd1;
  localparam inc_t INC_Y    = 2'd2;
  localparam inc_t INC_SP   = 2'd3;

  typedef enum logic [1:0] {IDLE, FETCH, WRITE} seq_state_t;

  function automatic logic sel_is_mem(input sel_t sel);
    return (sel == SEL_MX) || (sel == SEL_MY) || (sel == SEL_MN) || (sel == SEL_MSP);
  endfunction

endpackage

`default_nettype wire
